/* common/sqrtPkg.sv */
package sqrtPkg;

	// Operand and result widths
	localparam int radicandWidth = 64;
	localparam int rootWidth = 32;
	localparam int remWidth = 33;

	// One root bit per stage, one register per stage
	localparam int sqrtLatency = rootWidth;

	// Partial remainder carries a sign bit above the final remainder
	localparam int partRemWidth = remWidth + 1;
	// Room for the two radicand bits shifted in below the remainder
	localparam int trialWidth = partRemWidth + 2;

	// Operation tag and the shadow index taken from it
	localparam int tagWidth = 32;
	localparam int shadowIdxWidth = $clog2(sqrtLatency);
	// Wide enough for root squared plus remainder
	localparam int checkWidth = radicandWidth + 2;

	// Completion counter and command/status word
	localparam int countWidth = 8;
	localparam int cmdStatWidth = 32;

	// State handed from one stage to the next
	typedef struct packed {
		logic                           valid;
		logic [radicandWidth-1:0]       radicand;
		logic signed [partRemWidth-1:0] rem;
		logic [rootWidth-1:0]           root;
		logic [tagWidth-1:0]            tag;
	} sqrtStageT;

	// Command view, as written by the host
	typedef struct packed {
		logic [cmdStatWidth-3:0] reserved;
		logic                    clearCount;
		logic                    start;
	} sqrtCmdT;

	// Status view, as read by the host
	typedef struct packed {
		logic [15:0]           reservedHigh;
		logic [countWidth-1:0] count;
		logic [4:0]            reservedLow;
		logic                  remMsb;
		logic                  done;
		logic                  busy;
	} sqrtStatT;

	// Same address, decoded by direction
	typedef union packed {
		sqrtCmdT  cmd;
		sqrtStatT stat;
	} sqrtCmdStatT;

endpackage

/* common/axiLitePkg.sv */
package axiLitePkg;

	// Bus widths
	localparam int axiAddrWidth = 8;
	localparam int axiDataWidth = 32;

	// Response codes
	localparam logic [1:0] respOkay = 2'd0;
	localparam logic [1:0] respSlvErr = 2'd2;

	// Register map, byte addresses
	localparam logic [axiAddrWidth-1:0] addrOpLow = 8'h00;
	localparam logic [axiAddrWidth-1:0] addrOpHigh = 8'h04;
	localparam logic [axiAddrWidth-1:0] addrCmdStat = 8'h08;
	localparam logic [axiAddrWidth-1:0] addrRoot = 8'h0C;
	localparam logic [axiAddrWidth-1:0] addrRem = 8'h10;

	// Manager to subordinate
	typedef struct packed {
		// Write address
		logic                    awvalid;
		logic [axiAddrWidth-1:0] awaddr;
		// Write data
		logic                    wvalid;
		logic [axiDataWidth-1:0] wdata;
		// Write response
		logic                    bready;
		// Read address
		logic                    arvalid;
		logic [axiAddrWidth-1:0] araddr;
		// Read data
		logic                    rready;
	} axiLiteReqT;

	// Subordinate to manager
	typedef struct packed {
		logic                    awready;
		logic                    wready;
		logic                    bvalid;
		logic [1:0]              bresp;
		logic                    arready;
		logic                    rvalid;
		logic [axiDataWidth-1:0] rdata;
		logic [1:0]              rresp;
	} axiLiteRspT;

endpackage

/* sqrtCore/sqrtStage.sv */
`timescale 1ns/1ns

module sqrtStage
	import sqrtPkg::*;
(
	input  logic      clock,
	input  logic      rstN,
	input  sqrtStageT stageIn,
	output sqrtStageT stageOut
);

	// Remainder with the next two radicand bits appended
	logic signed [trialWidth-1:0] shifted;
	// Trial value built from the partial root
	logic signed [trialWidth-1:0] trial;
	logic signed [trialWidth-1:0] nextRem;
	logic [rootWidth-1:0]         nextRoot;

	always_comb begin
		// Shift in the top radicand pair, sign stays on top
		shifted = {stageIn.rem, stageIn.radicand[radicandWidth-1 -: 2]};

		// Non-restoring step, sign of the old remainder picks the operation
		if (stageIn.rem[partRemWidth-1]) begin
			// Negative: add 4Q+3
			trial = {2'b00, stageIn.root, 2'b11};
			nextRem = shifted + trial;
		end else begin
			// Non-negative: subtract 4Q+1
			trial = {2'b00, stageIn.root, 2'b01};
			nextRem = shifted - trial;
		end

		// New root bit is the inverted sign of the result
		nextRoot = {stageIn.root[rootWidth-2:0], ~nextRem[trialWidth-1]};
	end

	always_ff @(posedge clock) begin
		// Consumed pair drops off the top
		stageOut.radicand <= stageIn.radicand << 2;
		// Bounded by twice the root, fits the narrower field
		stageOut.rem <= nextRem[partRemWidth-1:0];
		stageOut.root <= nextRoot;
		stageOut.tag <= stageIn.tag;

		if (!rstN) begin
			stageOut.valid <= 1'b0;
		end else begin
			stageOut.valid <= stageIn.valid;
		end
	end

endmodule

/* sqrtCore/sqrtPipeline.sv */
`timescale 1ns/1ns

module sqrtPipeline
	import sqrtPkg::*;
(
	input  logic      clock,
	input  logic      rstN,
	input  sqrtStageT launch,
	output sqrtStageT result,
	output logic      busy
);

	// Entry 0 is the launch, entry k the output of stage k-1
	sqrtStageT chain [0:rootWidth];

	// Last stage remainder before and after correction
	logic signed [partRemWidth-1:0] lastRem;
	logic signed [partRemWidth-1:0] corrRem;
	logic [remWidth-1:0]            fixedRem;

	// Original radicands kept for the result check
	logic [radicandWidth-1:0] shadowRad [sqrtLatency];
	logic [checkWidth-1:0]    checkSum;
	logic [checkWidth-1:0]    checkRef;

	assign chain[0] = launch;

	for (genvar i = 0; i < rootWidth; i++) begin : gStage
		sqrtStage stage_i (
			.clock    (clock),
			.rstN     (rstN),
			.stageIn  (chain[i]),
			.stageOut (chain[i+1])
		);
	end

	always_comb begin
		lastRem = chain[rootWidth].rem;
		// Restoring step for a negative remainder: add 2Q+1
		corrRem = lastRem + $signed({1'b0, chain[rootWidth].root, 1'b1});
		if (lastRem[partRemWidth-1]) begin
			fixedRem = corrRem[remWidth-1:0];
		end else begin
			fixedRem = lastRem[remWidth-1:0];
		end

		result = chain[rootWidth];
		result.rem = $signed({1'b0, fixedRem});
	end

	// Anything in the launch register or any stage counts as in flight
	always_comb begin
		busy = 1'b0;
		for (int k = 0; k <= rootWidth; k++) begin
			busy = busy | chain[k].valid;
		end
	end

	// At most sqrtLatency ops in flight, so the low tag bits never collide
	always_ff @(posedge clock) begin
		if (launch.valid) begin
			shadowRad[launch.tag[shadowIdxWidth-1:0]] <= launch.radicand;
		end
	end

	always_comb begin
		checkSum = checkWidth'(result.root) * checkWidth'(result.root) + checkWidth'(fixedRem);
		checkRef = checkWidth'(shadowRad[result.tag[shadowIdxWidth-1:0]]);
	end

	// Root and remainder rebuild the radicand launched 32 cycles earlier
	aRootExact: assert property (@(posedge clock) disable iff (!rstN)
		result.valid |-> checkSum == checkRef)
		else $error("Root squared plus remainder differs from radicand");

	// Otherwise the root would be one too small
	aRemBound: assert property (@(posedge clock) disable iff (!rstN)
		result.valid |-> fixedRem <= {result.root, 1'b0})
		else $error("Remainder exceeds twice the root");

endmodule

/* hw/sqrtRegs.sv */
`timescale 1ns/1ns

module sqrtRegs
	import sqrtPkg::*, axiLitePkg::*;
(
	input  logic       clock,
	input  logic       rstN,
	input  axiLiteReqT bus,
	output axiLiteRspT busRsp,
	output sqrtStageT  launch,
	input  sqrtStageT  result,
	input  logic       busy
);

	// Write channel
	logic       awreadyQ;
	logic       bvalidQ;
	logic [1:0] brespQ;
	logic       wrFire;
	logic       wrOk;

	// Read channel
	logic                    arreadyQ;
	logic                    rvalidQ;
	logic [axiDataWidth-1:0] rdataQ;
	logic [1:0]              rrespQ;
	logic                    rdFire;
	logic                    rdOk;
	logic [axiDataWidth-1:0] rdMux;

	// Host-visible registers
	logic [axiDataWidth-1:0] opLow;
	logic [axiDataWidth-1:0] opHigh;
	logic [rootWidth-1:0]    rootReg;
	logic [remWidth-1:0]     remReg;
	logic                    doneQ;
	logic [countWidth-1:0]   countQ;

	// Command decode and status build
	sqrtCmdStatT cmdWord;
	sqrtCmdStatT statWord;
	logic        cmdHit;
	logic        startFire;
	logic        clearFire;

	// Launch register
	logic                     launchValid;
	logic [radicandWidth-1:0] launchRad;
	logic [tagWidth-1:0]      launchTag;
	logic [tagWidth-1:0]      tagQ;

	// Both channels handshake in the cycle ready is high
	assign wrFire = awreadyQ && bus.awvalid && bus.wvalid;
	assign rdFire = arreadyQ && bus.arvalid;

	assign cmdWord = bus.wdata;
	assign cmdHit = wrFire && (bus.awaddr == addrCmdStat);
	assign startFire = cmdHit && cmdWord.cmd.start;
	assign clearFire = cmdHit && cmdWord.cmd.clearCount;

	// Root and remainder are read only
	always_comb begin
		case (bus.awaddr)
			addrOpLow, addrOpHigh, addrCmdStat: wrOk = 1'b1;
			default: wrOk = 1'b0;
		endcase
	end

	always_comb begin
		statWord = '0;
		statWord.stat.busy = busy;
		statWord.stat.done = doneQ;
		// Bit 32 of the remainder does not fit the data word
		statWord.stat.remMsb = remReg[remWidth-1];
		statWord.stat.count = countQ;
	end

	always_comb begin
		rdOk = 1'b1;
		case (bus.araddr)
			addrOpLow: rdMux = opLow;
			addrOpHigh: rdMux = opHigh;
			addrCmdStat: rdMux = statWord;
			addrRoot: rdMux = rootReg;
			addrRem: rdMux = remReg[axiDataWidth-1:0];
			default: begin
				rdMux = '0;
				rdOk = 1'b0;
			end
		endcase
	end

	// Ready pulses once per request, blocked while a response waits
	always_ff @(posedge clock) begin
		if (!rstN) begin
			awreadyQ <= 1'b0;
			bvalidQ <= 1'b0;
			arreadyQ <= 1'b0;
			rvalidQ <= 1'b0;
		end else begin
			awreadyQ <= bus.awvalid && bus.wvalid && !bvalidQ && !awreadyQ;
			if (wrFire) begin
				bvalidQ <= 1'b1;
			end else if (bus.bready) begin
				bvalidQ <= 1'b0;
			end

			arreadyQ <= bus.arvalid && !rvalidQ && !arreadyQ;
			if (rdFire) begin
				rvalidQ <= 1'b1;
			end else if (bus.rready) begin
				rvalidQ <= 1'b0;
			end
		end
	end

	// Response payload, held until the next handshake
	always_ff @(posedge clock) begin
		if (wrFire) begin
			brespQ <= wrOk ? respOkay : respSlvErr;
		end
		if (rdFire) begin
			rdataQ <= rdMux;
			rrespQ <= rdOk ? respOkay : respSlvErr;
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			opLow <= '0;
			opHigh <= '0;
			rootReg <= '0;
			remReg <= '0;
			doneQ <= 1'b0;
			countQ <= '0;
			tagQ <= '0;
			launchValid <= 1'b0;
		end else begin
			if (wrFire && (bus.awaddr == addrOpLow)) begin
				opLow <= bus.wdata;
			end
			if (wrFire && (bus.awaddr == addrOpHigh)) begin
				opHigh <= bus.wdata;
			end

			// Start launches even when clear comes with it
			launchValid <= startFire;
			if (startFire) begin
				tagQ <= tagQ + 1'b1;
			end

			// Last completion wins
			if (result.valid) begin
				rootReg <= result.root;
				remReg <= result.rem[remWidth-1:0];
			end

			// Clear first, so a completion in the same cycle still counts
			doneQ <= (doneQ && !clearFire) || result.valid;
			countQ <= (clearFire ? '0 : countQ) + countWidth'(result.valid);
		end
	end

	always_ff @(posedge clock) begin
		if (startFire) begin
			launchRad <= {opHigh, opLow};
			launchTag <= tagQ;
		end
	end

	always_comb begin
		launch.valid = launchValid;
		launch.radicand = launchRad;
		launch.rem = '0;
		launch.root = '0;
		launch.tag = launchTag;
	end

	always_comb begin
		busRsp.awready = awreadyQ;
		busRsp.wready = awreadyQ;
		busRsp.bvalid = bvalidQ;
		busRsp.bresp = brespQ;
		busRsp.arready = arreadyQ;
		busRsp.rvalid = rvalidQ;
		busRsp.rdata = rdataQ;
		busRsp.rresp = rrespQ;
	end

	// Responses hold until the manager takes them
	aBHold: assert property (@(posedge clock) disable iff (!rstN)
		bvalidQ && !bus.bready |=> bvalidQ && $stable(brespQ))
		else $error("Write response changed before bready");

	aRHold: assert property (@(posedge clock) disable iff (!rstN)
		rvalidQ && !bus.rready |=> rvalidQ && $stable(rdataQ) && $stable(rrespQ))
		else $error("Read data changed before rready");

endmodule

/* hw/sqrtAccel.sv */
`timescale 1ns/1ns

module sqrtAccel
	import sqrtPkg::*, axiLitePkg::*;
(
	input  logic       clock,
	input  logic       rstN,
	input  axiLiteReqT bus,
	output axiLiteRspT busRsp
);

	// Register block to pipeline
	sqrtStageT launch;
	// Pipeline back to register block
	sqrtStageT result;
	logic      busy;

	// Bus slave, operand and result registers
	sqrtRegs regs_i (
		.clock  (clock),
		.rstN   (rstN),
		.bus    (bus),
		.busRsp (busRsp),
		.launch (launch),
		.result (result),
		.busy   (busy)
	);

	// 32 stages, one op per cycle
	sqrtPipeline pipe_i (
		.clock  (clock),
		.rstN   (rstN),
		.launch (launch),
		.result (result),
		.busy   (busy)
	);

endmodule

/* tb/tbClock.sv */
`timescale 1ns/1ns

module tbClock (
	output logic clock,
	output logic rstN
);

	// 8 ns period
	localparam int halfPeriod = 4;
	localparam int resetCycles = 8;

	initial begin
		clock = 1'b0;
		forever begin
			#halfPeriod clock = ~clock;
		end
	end

	// Released on a rising edge, the DUT reset is synchronous
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clock);
		rstN <= 1'b1;
	end

endmodule

/* tb/sqrtChecker.sv */
`timescale 1ns/1ns

module sqrtChecker
	import sqrtPkg::*, axiLitePkg::*;
(
	input  logic       clock,
	input  logic       rstN,
	input  axiLiteReqT bus,
	input  axiLiteRspT busRsp,
	input  logic [1:0] expResp,
	input  int         testNum,
	input  logic       allDone,
	output int         errCount
);

	// Result registers update one edge after the last stage
	localparam int doneDelay = sqrtLatency + 1;

	// Reference copy of the host-visible registers
	logic [axiDataWidth-1:0] opLow;
	logic [axiDataWidth-1:0] opHigh;
	logic [rootWidth-1:0]    root;
	logic [remWidth-1:0]     rem;
	logic                    done;
	logic [7:0]              count;
	// Launch edge and radicand of every op in flight, oldest first
	longint                  launchCyc[$];
	logic [63:0]             launchRad[$];
	longint                  cyc;
	logic [axiDataWidth-1:0] expData;
	// Write response seen with bready low on the last edge
	bit                      bHeld;
	logic [1:0]              bHeldResp;
	int                      checks;
	int                      testChecks;
	int                      testErrs;
	int                      curTest;
	bit                      reported;

	// Largest r with r*r <= x, one root bit at a time
	function automatic logic [127:0] isqrt(input logic [127:0] x);
		logic [127:0] r;
		logic [127:0] c;
		r = '0;
		for (int b = rootWidth - 1; b >= 0; b--) begin
			c = r | (128'd1 << b);
			if (c * c <= x) begin
				r = c;
			end
		end
		return r;
	endfunction

	// What a read of addr returns, from the model state
	function automatic logic [axiDataWidth-1:0] modelRead(input logic [axiAddrWidth-1:0] addr,
		input logic busy);
		case (addr)
			addrOpLow: return opLow;
			addrOpHigh: return opHigh;
			// Count in 15:8, remainder MSB, done, busy in the low bits
			addrCmdStat: return {16'h0, count, 5'h0, rem[remWidth-1], done, busy};
			addrRoot: return root;
			addrRem: return rem[axiDataWidth-1:0];
			default: return '0;
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		testChecks++;
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errCount++;
			testErrs++;
		end
	endtask

	task automatic reportTest();
		$display("Test %0d finished with %0d checks and %0d errors", curTest, testChecks, testErrs);
	endtask

	// Sampled on the edge, every DUT input and output changes after it
	always @(posedge clock) begin
		logic [127:0] x;
		logic [127:0] r;
		if (!rstN) begin
			opLow = '0;
			opHigh = '0;
			root = '0;
			rem = '0;
			done = 1'b0;
			count = '0;
			cyc = 0;
			bHeld = 1'b0;
			errCount = 0;
			launchCyc.delete();
			launchRad.delete();
		end else begin
			if (testNum != curTest) begin
				if (curTest != 0) begin
					reportTest();
				end
				curTest = testNum;
				testChecks = 0;
				testErrs = 0;
			end

			// Responses taken on this edge
			if (busRsp.bvalid && bus.bready) begin
				compare("bresp", 32'(busRsp.bresp), 32'(expResp));
			end
			if (busRsp.rvalid && bus.rready) begin
				compare("rdata", busRsp.rdata, expData);
				compare("rresp", 32'(busRsp.rresp), 32'(expResp));
			end

			// Waiting write response must stay put
			if (bHeld) begin
				if (!busRsp.bvalid) begin
					$display("At %0t ns bvalid dropped before bready was seen", $time);
					errCount++;
					testErrs++;
				end
				compare("bresp held", 32'(busRsp.bresp), 32'(bHeldResp));
			end
			bHeld = busRsp.bvalid && !bus.bready;
			bHeldResp = busRsp.bresp;

			// Read data comes from the state before this edge
			if (busRsp.arready && bus.arvalid) begin
				expData = modelRead(bus.araddr, launchCyc.size() != 0);
			end

			if (busRsp.awready && bus.awvalid && bus.wvalid) begin
				case (bus.awaddr)
					addrOpLow: opLow = bus.wdata;
					addrOpHigh: opHigh = bus.wdata;
					addrCmdStat: begin
						// Clear goes first, then start
						if (bus.wdata[1]) begin
							done = 1'b0;
							count = '0;
						end
						if (bus.wdata[0]) begin
							launchCyc.push_back(cyc);
							launchRad.push_back({opHigh, opLow});
						end
					end
					default: ;
				endcase
			end

			// In-order completion, last one wins
			if (launchCyc.size() != 0 && cyc == launchCyc[0] + doneDelay) begin
				x = 128'(launchRad.pop_front());
				void'(launchCyc.pop_front());
				r = isqrt(x);
				root = r[rootWidth-1:0];
				rem = remWidth'(x - r * r);
				done = 1'b1;
				count++;
			end
			cyc++;
		end

		if (allDone && !reported) begin
			reportTest();
			$display("All tests finished with %0d checks and %0d errors", checks, errCount);
			reported = 1'b1;
		end
	end

endmodule

/* tb/sqrtAccelTb.sv */
`timescale 1ns/1ns

module sqrtAccelTb
	import axiLitePkg::*;
();

	// Step kinds of the stimulus table
	localparam int opTest = 0;
	localparam int opWrite = 1;
	localparam int opWriteHold = 2;
	localparam int opRead = 3;
	localparam int opSqrt = 4;
	localparam int opRandom = 5;
	localparam int opWait = 6;

	localparam int waitLimit = 200;
	localparam int pollLimit = 40;
	localparam int holdCycles = 5;

	typedef struct {
		int                      kind;
		logic [axiAddrWidth-1:0] addr;
		logic [63:0]             data;
		logic [1:0]              resp;
	} stepT;

	logic       clock;
	logic       rstN;
	axiLiteReqT bus;
	axiLiteRspT busRsp;
	logic [1:0] expResp;
	int         testNum;
	logic       allDone;
	int         errCount;
	bit         timedOut;
	longint     cyc = 0;
	// Edge of the most recent write handshake
	longint     lastB;
	stepT       steps[$];

	tbClock clock_i (
		.clock (clock),
		.rstN  (rstN)
	);

	sqrtAccel dut_i (
		.clock  (clock),
		.rstN   (rstN),
		.bus    (bus),
		.busRsp (busRsp)
	);

	sqrtChecker check_i (
		.clock    (clock),
		.rstN     (rstN),
		.bus      (bus),
		.busRsp   (busRsp),
		.expResp  (expResp),
		.testNum  (testNum),
		.allDone  (allDone),
		.errCount (errCount)
	);

	always @(posedge clock) begin
		cyc <= cyc + 1;
	end

	function automatic void addStep(input int kind, input logic [7:0] addr,
		input logic [63:0] data, input logic [1:0] resp);
		stepT s;
		s.kind = kind;
		s.addr = addr;
		s.data = data;
		s.resp = resp;
		steps.push_back(s);
	endfunction

	task automatic reportTimeout(input string what);
		$display("Timeout at %0t ns while waiting for %s", $time, what);
		timedOut = 1'b1;
	endtask

	// AW and W together, bready low for a while when hold is set
	task automatic writeWord(input logic [7:0] addr, input logic [31:0] data,
		input logic [1:0] resp, input bit hold);
		int n;
		if (timedOut) begin
			return;
		end
		expResp <= resp;
		bus.awvalid <= 1'b1;
		bus.awaddr <= addr;
		bus.wvalid <= 1'b1;
		bus.wdata <= data;
		n = 0;
		do begin
			@(posedge clock);
			n++;
		end while (!(busRsp.awready && busRsp.wready) && n < waitLimit);
		bus.awvalid <= 1'b0;
		bus.wvalid <= 1'b0;
		bus.bready <= !hold;
		if (!(busRsp.awready && busRsp.wready)) begin
			reportTimeout("awready and wready");
			return;
		end
		n = 0;
		do begin
			@(posedge clock);
			n++;
		end while (!busRsp.bvalid && n < waitLimit);
		if (!busRsp.bvalid) begin
			bus.bready <= 1'b0;
			reportTimeout("bvalid");
			return;
		end
		// bvalid rose one edge back
		lastB = cyc - 1;
		if (hold) begin
			repeat (holdCycles) @(posedge clock);
			bus.bready <= 1'b1;
			@(posedge clock);
		end
		bus.bready <= 1'b0;
	endtask

	task automatic readWord(input logic [7:0] addr, input logic [1:0] resp,
		output logic [31:0] data);
		int n;
		data = '0;
		if (timedOut) begin
			return;
		end
		expResp <= resp;
		bus.arvalid <= 1'b1;
		bus.araddr <= addr;
		n = 0;
		do begin
			@(posedge clock);
			n++;
		end while (!busRsp.arready && n < waitLimit);
		bus.arvalid <= 1'b0;
		if (!busRsp.arready) begin
			reportTimeout("arready");
			return;
		end
		bus.rready <= 1'b1;
		n = 0;
		do begin
			@(posedge clock);
			n++;
		end while (!busRsp.rvalid && n < waitLimit);
		bus.rready <= 1'b0;
		if (!busRsp.rvalid) begin
			reportTimeout("rvalid");
			return;
		end
		data = busRsp.rdata;
	endtask

	// Load operand, clear and start, poll for done, read both results
	task automatic runSqrt(input logic [63:0] x);
		logic [31:0] stat;
		logic [31:0] word;
		int n;
		writeWord(addrOpLow, x[31:0], respOkay, 1'b0);
		writeWord(addrOpHigh, x[63:32], respOkay, 1'b0);
		writeWord(addrCmdStat, 32'h3, respOkay, 1'b0);
		stat = '0;
		n = 0;
		while (!stat[1] && !timedOut && n < pollLimit) begin
			readWord(addrCmdStat, respOkay, stat);
			n++;
		end
		if (!stat[1] && !timedOut) begin
			reportTimeout("the done bit");
		end
		readWord(addrRoot, respOkay, word);
		readWord(addrRem, respOkay, word);
	endtask

	// Counted from the edge where the last bvalid rose
	task automatic waitAfterWrite(input int cycles);
		int n;
		n = 0;
		while (cyc < lastB + cycles && n < waitLimit) begin
			@(posedge clock);
			n++;
		end
		if (cyc < lastB + cycles) begin
			reportTimeout("a cycle count after the last write");
		end
	endtask

	task automatic buildTable();
		// Edge radicands, status read covers the remainder MSB
		addStep(opTest, 8'h00, 64'd1, respOkay);
		addStep(opSqrt, 8'h00, 64'd0, respOkay);
		addStep(opSqrt, 8'h00, 64'd1, respOkay);
		addStep(opSqrt, 8'h00, 64'd2, respOkay);
		addStep(opSqrt, 8'h00, 64'd3, respOkay);
		addStep(opSqrt, 8'h00, 64'd4, respOkay);
		addStep(opSqrt, 8'h00, 64'd1524157875019052100, respOkay);
		addStep(opSqrt, 8'h00, 64'hFFFF_FFFF_FFFF_FFFF, respOkay);
		addStep(opSqrt, 8'h00, 64'h8000_0000_0000_0000, respOkay);
		addStep(opTest, 8'h00, 64'd2, respOkay);
		addStep(opRandom, 8'h00, 64'd20, respOkay);
		// Busy right after start, done lands on the 33rd cycle
		addStep(opTest, 8'h00, 64'd3, respOkay);
		addStep(opWrite, addrCmdStat, 64'h2, respOkay);
		addStep(opWrite, addrOpLow, 64'h89AB_CDEF, respOkay);
		addStep(opWrite, addrOpHigh, 64'h0000_3456, respOkay);
		addStep(opWrite, addrCmdStat, 64'h1, respOkay);
		addStep(opRead, addrCmdStat, 64'h0, respOkay);
		addStep(opWait, 8'h00, 64'd31, respOkay);
		addStep(opRead, addrCmdStat, 64'h0, respOkay);
		addStep(opRead, addrCmdStat, 64'h0, respOkay);
		addStep(opRead, addrRoot, 64'h0, respOkay);
		// Clear and start again, status read lands just after done
		addStep(opWrite, addrCmdStat, 64'h3, respOkay);
		addStep(opWait, 8'h00, 64'd32, respOkay);
		addStep(opRead, addrCmdStat, 64'h0, respOkay);
		// Two ops in flight, second result stays
		addStep(opTest, 8'h00, 64'd4, respOkay);
		addStep(opWrite, addrOpLow, 64'd81, respOkay);
		addStep(opWrite, addrOpHigh, 64'd0, respOkay);
		addStep(opWrite, addrCmdStat, 64'h3, respOkay);
		addStep(opWrite, addrOpLow, 64'h89AB_CDEF, respOkay);
		addStep(opWrite, addrOpHigh, 64'h0123_4567, respOkay);
		addStep(opWrite, addrCmdStat, 64'h1, respOkay);
		addStep(opWait, 8'h00, 64'd40, respOkay);
		addStep(opRead, addrCmdStat, 64'h0, respOkay);
		addStep(opRead, addrRoot, 64'h0, respOkay);
		addStep(opRead, addrRem, 64'h0, respOkay);
		addStep(opTest, 8'h00, 64'd5, respOkay);
		addStep(opWrite, addrCmdStat, 64'h2, respOkay);
		addStep(opRead, addrCmdStat, 64'h0, respOkay);
		// Unmapped and read-only addresses
		addStep(opTest, 8'h00, 64'd6, respOkay);
		addStep(opRead, 8'h20, 64'h0, respSlvErr);
		addStep(opWrite, 8'h20, 64'h55, respSlvErr);
		addStep(opWrite, addrRoot, 64'h1234, respSlvErr);
		addStep(opRead, addrRoot, 64'h0, respOkay);
		addStep(opWriteHold, 8'h14, 64'h77, respSlvErr);
		addStep(opWriteHold, addrOpLow, 64'hA5A5_0F0F, respOkay);
		addStep(opRead, addrOpLow, 64'h0, respOkay);
	endtask

	initial begin
		logic [31:0] rdData;
		logic [63:0] x;
		int n;
		bus = '0;
		expResp = respOkay;
		testNum = 0;
		allDone = 1'b0;
		timedOut = 1'b0;
		lastB = 0;
		void'($urandom(3255));
		buildTable();

		n = 0;
		while (!rstN && n < waitLimit) begin
			@(posedge clock);
			n++;
		end
		if (!rstN) begin
			reportTimeout("reset release");
		end

		for (int i = 0; i < steps.size() && !timedOut; i++) begin
			case (steps[i].kind)
				opTest: testNum <= int'(steps[i].data);
				opWrite: writeWord(steps[i].addr, steps[i].data[31:0], steps[i].resp, 1'b0);
				opWriteHold: writeWord(steps[i].addr, steps[i].data[31:0], steps[i].resp, 1'b1);
				opRead: readWord(steps[i].addr, steps[i].resp, rdData);
				opSqrt: runSqrt(steps[i].data);
				opRandom: begin
					for (int r = 0; r < int'(steps[i].data); r++) begin
						x[63:32] = $urandom;
						x[31:0] = $urandom;
						runSqrt(x);
					end
				end
				opWait: waitAfterWrite(int'(steps[i].data));
				default: ;
			endcase
		end

		// Let the checker print its summary
		allDone <= 1'b1;
		repeat (2) @(posedge clock);
		if (timedOut || errCount != 0) begin
			$display("Testbench failed");
		end else begin
			$display("Testbench passed");
		end
		$finish;
	end

endmodule

/* sim.f */
common/sqrtPkg.sv
common/axiLitePkg.sv
sqrtCore/sqrtStage.sv
sqrtCore/sqrtPipeline.sv
hw/sqrtRegs.sv
hw/sqrtAccel.sv
tb/tbClock.sv
tb/sqrtChecker.sv
tb/sqrtAccelTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the square-root accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log
buildDir=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module sqrtAccelTb -f sim.f -Mdir "$buildDir" -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/simv" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Testbench failed" "$logFile"; then
	exit 1
fi
exit 0
